/* rtl/alu_ops_pkg.sv */
// ----------------------------------------------------------------------
// Shared types for the ALU-operations engine. Ops are 4-bit codes.
// Codes outside alu_op_t pass the data through unchanged.
// ----------------------------------------------------------------------
package alu_ops_pkg;

    localparam int data_width = 32;
    localparam int id_width   = 8;

    // Operation codes, min and max compare unsigned
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_mul = 4'd2,
        op_and = 4'd3,
        op_or  = 4'd4,
        op_xor = 4'd5,
        op_min = 4'd6,
        op_max = 4'd7
    } alu_op_t;

    // Field selector carried by every configuration packet
    typedef enum logic [1:0] {
        field_op      = 2'd0,
        field_operand = 2'd1,
        field_commit  = 2'd2,
        field_clear   = 2'd3
    } cfg_field_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
    } engine_payload_t;

    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    typedef struct packed {
        cfg_field_t            field;
        logic [data_width-1:0] value;
    } config_payload_t;

    typedef struct packed {
        logic            valid;
        config_payload_t payload;
    } config_packet_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

    // Status of a FIFO with nothing in it
    localparam fifo_status_t fifo_status_idle = '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};

    typedef struct packed {
        alu_op_t               op;
        logic [data_width-1:0] operand;
    } alu_config_t;

endpackage : alu_ops_pkg

/* rtl/sync_fifo.sv */
// ----------------------------------------------------------------------
// Writes while full are dropped; the caller must watch status.full.
// Read data and valid come one cycle after an accepted rd_en.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t   = logic [7:0],
    parameter int  fifo_depth  = 32,
    parameter int  prog_thresh = 16
) (
    input  logic                      ap_clk,
    input  logic                      areset_csr_engine,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  payload_t                  din,
    output payload_t                  dout,
    output logic                      valid,
    output alu_ops_pkg::fifo_status_t status
);

    localparam int addr_width  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int count_width = $clog2(fifo_depth + 1);

    payload_t mem [fifo_depth];

    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] count;
    logic                   do_wr;
    logic                   do_rd;

    // Status straight from the occupancy counter
    assign status.full      = (count == count_width'(fifo_depth));
    assign status.empty     = (count == '0);
    assign status.prog_full = (count >= count_width'(prog_thresh));

    assign do_wr = wr_en & ~status.full;
    assign do_rd = rd_en & ~status.empty;

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == addr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == addr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Registered read port, valid pulses once per pop
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            valid <= 1'b0;
        end else begin
            valid <= do_rd;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

/* rtl/alu_ops_configure.sv */
// ----------------------------------------------------------------------
// Drains the configuration FIFO and holds the committed settings.
// Change settings only while no engine packets are in flight.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_ops_configure (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  alu_ops_pkg::config_payload_t config_in,
    input  logic                         config_in_valid,
    input  logic                         config_empty,
    output logic                         config_rd_en,
    output alu_ops_pkg::alu_config_t     alu_config,
    output logic                         config_valid
);

    import alu_ops_pkg::*;

    // Nothing stalls configuration traffic
    assign config_rd_en = ~config_empty;

    // ------------------------------------------------------------------
    // Field decode
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            alu_config.op      <= op_add;
            alu_config.operand <= '0;
            config_valid       <= 1'b0;
        end else if (config_in_valid) begin
            case (config_in.field)
                field_op: begin
                    // Unnamed codes are kept and later pass data through
                    alu_config.op <= alu_op_t'(config_in.value[3:0]);
                end
                field_operand: begin
                    alu_config.operand <= config_in.value;
                end
                field_commit: begin
                    config_valid <= 1'b1;
                end
                field_clear: begin
                    config_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule : alu_ops_configure

/* rtl/alu_ops_generator.sv */
// ----------------------------------------------------------------------
// One registered ALU stage after the FIFO read, so two packets at most
// are in flight; the output FIFO's prog_full must leave room for them.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module alu_ops_generator (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  alu_ops_pkg::alu_config_t     alu_config,
    input  logic                         config_valid,
    input  alu_ops_pkg::engine_payload_t engine_in,
    input  logic                         engine_in_valid,
    input  logic                         engine_empty,
    input  logic                         out_prog_full,
    output logic                         engine_rd_en,
    output alu_ops_pkg::engine_packet_t  request_out
);

    import alu_ops_pkg::*;

    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic [data_width-1:0] alu_result;

    // ------------------------------------------------------------------
    // Pop control
    // ------------------------------------------------------------------
    // Hold off until committed and the output has headroom
    assign engine_rd_en = ~engine_empty & config_valid & ~out_prog_full;

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    assign operand_a = engine_in.data;
    assign operand_b = alu_config.operand;

    always_comb begin
        case (alu_config.op)
            op_add: begin
                alu_result = operand_a + operand_b;
            end
            op_sub: begin
                alu_result = operand_a - operand_b;
            end
            op_mul: begin
                // Low half of the product only
                alu_result = operand_a * operand_b;
            end
            op_and: begin
                alu_result = operand_a & operand_b;
            end
            op_or: begin
                alu_result = operand_a | operand_b;
            end
            op_xor: begin
                alu_result = operand_a ^ operand_b;
            end
            op_min: begin
                alu_result = (operand_a < operand_b) ? operand_a : operand_b;
            end
            op_max: begin
                alu_result = (operand_a > operand_b) ? operand_a : operand_b;
            end
            default: begin
                alu_result = operand_a;
            end
        endcase
    end

    // Result register, id travels alongside unchanged
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= engine_in_valid;
        end
        request_out.payload.id   <= engine_in.id;
        request_out.payload.data <= alu_result;
    end

endmodule : alu_ops_generator

/* rtl/engine_alu_ops.sv */
// ----------------------------------------------------------------------
// Upstream must not send while the matching status shows full.
// Inputs, rd_en and all outputs pass through one register each.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module engine_alu_ops #(
    parameter int fifo_depth  = 32,
    parameter int prog_thresh = 16
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  alu_ops_pkg::engine_packet_t response_engine_in,
    input  alu_ops_pkg::config_packet_t response_memory_in,
    input  logic                        request_engine_out_rd_en,
    output alu_ops_pkg::engine_packet_t request_engine_out,
    output alu_ops_pkg::fifo_status_t   response_engine_in_status,
    output alu_ops_pkg::fifo_status_t   response_memory_in_status,
    output alu_ops_pkg::fifo_status_t   request_engine_out_status
);

    import alu_ops_pkg::*;

    engine_packet_t  response_engine_in_reg;
    config_packet_t  response_memory_in_reg;
    logic            request_rd_en_reg;

    engine_payload_t engine_fifo_dout;
    logic            engine_fifo_valid;
    logic            engine_fifo_rd_en;
    fifo_status_t    engine_fifo_status;

    config_payload_t memory_fifo_dout;
    logic            memory_fifo_valid;
    logic            memory_fifo_rd_en;
    fifo_status_t    memory_fifo_status;

    engine_payload_t out_fifo_dout;
    logic            out_fifo_valid;
    logic            out_fifo_rd_en;
    fifo_status_t    out_fifo_status;

    alu_config_t     alu_config;
    logic            config_valid;
    engine_packet_t  generator_out;

    // ------------------------------------------------------------------
    // Input boundary
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            response_engine_in_reg.valid <= 1'b0;
            response_memory_in_reg.valid <= 1'b0;
            request_rd_en_reg            <= 1'b0;
        end else begin
            response_engine_in_reg.valid <= response_engine_in.valid;
            response_memory_in_reg.valid <= response_memory_in.valid;
            request_rd_en_reg            <= request_engine_out_rd_en;
        end
        response_engine_in_reg.payload <= response_engine_in.payload;
        response_memory_in_reg.payload <= response_memory_in.payload;
    end

    // ------------------------------------------------------------------
    // Output boundary
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_engine_out.valid  <= 1'b0;
            response_engine_in_status <= fifo_status_idle;
            response_memory_in_status <= fifo_status_idle;
            request_engine_out_status <= fifo_status_idle;
        end else begin
            request_engine_out.valid  <= out_fifo_valid;
            response_engine_in_status <= engine_fifo_status;
            response_memory_in_status <= memory_fifo_status;
            request_engine_out_status <= out_fifo_status;
        end
        request_engine_out.payload <= out_fifo_dout;
    end

    // External consumer pops only what is there
    assign out_fifo_rd_en = request_rd_en_reg & ~out_fifo_status.empty;

    // ------------------------------------------------------------------
    // FIFOs
    // ------------------------------------------------------------------
    sync_fifo #(
        .payload_t  (engine_payload_t),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) i_fifo_engine_in (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en            (response_engine_in_reg.valid),
        .rd_en            (engine_fifo_rd_en),
        .din              (response_engine_in_reg.payload),
        .dout             (engine_fifo_dout),
        .valid            (engine_fifo_valid),
        .status           (engine_fifo_status)
    );

    sync_fifo #(
        .payload_t  (config_payload_t),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) i_fifo_memory_in (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en            (response_memory_in_reg.valid),
        .rd_en            (memory_fifo_rd_en),
        .din              (response_memory_in_reg.payload),
        .dout             (memory_fifo_dout),
        .valid            (memory_fifo_valid),
        .status           (memory_fifo_status)
    );

    sync_fifo #(
        .payload_t  (engine_payload_t),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) i_fifo_engine_out (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en            (generator_out.valid),
        .rd_en            (out_fifo_rd_en),
        .din              (generator_out.payload),
        .dout             (out_fifo_dout),
        .valid            (out_fifo_valid),
        .status           (out_fifo_status)
    );

    // ------------------------------------------------------------------
    // Configuration and generation
    // ------------------------------------------------------------------
    alu_ops_configure i_alu_ops_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .config_in        (memory_fifo_dout),
        .config_in_valid  (memory_fifo_valid),
        .config_empty     (memory_fifo_status.empty),
        .config_rd_en     (memory_fifo_rd_en),
        .alu_config       (alu_config),
        .config_valid     (config_valid)
    );

    alu_ops_generator i_alu_ops_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .alu_config       (alu_config),
        .config_valid     (config_valid),
        .engine_in        (engine_fifo_dout),
        .engine_in_valid  (engine_fifo_valid),
        .engine_empty     (engine_fifo_status.empty),
        .out_prog_full    (out_fifo_status.prog_full),
        .engine_rd_en     (engine_fifo_rd_en),
        .request_out      (generator_out)
    );

endmodule : engine_alu_ops

/* bench/engine_alu_ops_properties.sv */
// ----------------------------------------------------------------------
// Bound into every sync_fifo. Checks the write side of the caller
// contract, that an empty FIFO returns no data, and the reset valid.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module engine_alu_ops_properties (
    input logic                      ap_clk,
    input logic                      areset_csr_engine,
    input logic                      wr_en,
    input logic                      valid,
    input alu_ops_pkg::fifo_status_t status
);

    // Writes into a full FIFO would be dropped
    no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        wr_en |-> !status.full)
        else $error("FIFO written while full");

    // An empty FIFO must not pop, whatever its caller asks for
    no_read_when_empty: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        status.empty |=> !valid)
        else $error("FIFO produced read data while empty");

    valid_low_in_reset: assert property (@(posedge ap_clk)
        areset_csr_engine |=> !valid)
        else $error("FIFO read valid high during reset");

endmodule : engine_alu_ops_properties

bind sync_fifo engine_alu_ops_properties i_engine_alu_ops_properties (
    .ap_clk           (ap_clk),
    .areset_csr_engine(areset_csr_engine),
    .wr_en            (wr_en),
    .valid            (valid),
    .status           (status)
);

/* bench/engine_alu_ops_tb.sv */
// ----------------------------------------------------------------------
// Runs the DUT with default FIFO depth and threshold. Back-pressure sends
// are five cycles apart so the registered full status is current.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module engine_alu_ops_tb;

    import alu_ops_pkg::*;

    localparam int packets_total   = 8 * 20 + 8 + 64 + 20;
    localparam int watchdog_cycles = packets_total * 40 + 500;

    logic            ap_clk;
    logic            areset_csr_engine;
    engine_packet_t  response_engine_in;
    config_packet_t  response_memory_in;
    logic            request_engine_out_rd_en;
    engine_packet_t  request_engine_out;
    fifo_status_t    response_engine_in_status;
    fifo_status_t    response_memory_in_status;
    fifo_status_t    request_engine_out_status;

    logic [31:0]     lfsr_state;
    logic [3:0]      model_op;
    logic [31:0]     model_operand;
    logic [7:0]      next_id;
    engine_payload_t expected_q[$];
    string           test_name;
    logic            hold_quiet;
    logic            saw_full;
    int              errors;
    int              errors_at_start;
    int              checks;
    int              tests_run;

    engine_alu_ops i_engine_alu_ops (
        .ap_clk                   (ap_clk),
        .areset_csr_engine        (areset_csr_engine),
        .response_engine_in       (response_engine_in),
        .response_memory_in       (response_memory_in),
        .request_engine_out_rd_en (request_engine_out_rd_en),
        .request_engine_out       (request_engine_out),
        .response_engine_in_status(response_engine_in_status),
        .response_memory_in_status(response_memory_in_status),
        .request_engine_out_status(request_engine_out_status)
    );

    always #50 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------
    // Reference model and stimulus helpers
    // ------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(int unsigned nbits);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] alu_ref(logic [3:0] op, logic [31:0] data,
                                            logic [31:0] operand);
        case (op)
            op_add:  return data + operand;
            op_sub:  return data - operand;
            op_mul:  return data * operand;
            op_and:  return data & operand;
            op_or:   return data | operand;
            op_xor:  return data ^ operand;
            op_min:  return (data < operand) ? data : operand;
            op_max:  return (data > operand) ? data : operand;
            default: return data;
        endcase
    endfunction

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic send_config(cfg_field_t field, logic [31:0] value);
        @(posedge ap_clk);
        response_engine_in.valid         <= 1'b0;
        response_memory_in.valid         <= 1'b1;
        response_memory_in.payload.field <= field;
        response_memory_in.payload.value <= value;
    endtask

    task automatic load_config(logic [3:0] op, logic [31:0] operand);
        model_op      = op;
        model_operand = operand;
        send_config(field_op, {28'd0, op});
        send_config(field_operand, operand);
    endtask

    task automatic configure_alu(logic [3:0] op, logic [31:0] operand);
        load_config(op, operand);
        send_config(field_commit, '0);
    endtask

    task automatic send_packet();
        engine_payload_t payload;
        engine_payload_t expected;
        payload.id    = next_id;
        payload.data  = random_bits(32);
        next_id       = next_id + 1'b1;
        expected.id   = payload.id;
        expected.data = alu_ref(model_op, payload.data, model_operand);
        expected_q.push_back(expected);
        @(posedge ap_clk);
        response_memory_in.valid   <= 1'b0;
        response_engine_in.valid   <= 1'b1;
        response_engine_in.payload <= payload;
    endtask

    task automatic idle_cycle();
        @(posedge ap_clk);
        response_engine_in.valid <= 1'b0;
        response_memory_in.valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge ap_clk);
        end
        repeat (2) @(posedge ap_clk);
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ------------------------------------------------------------------
    // Scoreboard, results leave in send order
    // ------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_csr_engine && request_engine_out.valid) begin
            if (hold_quiet) begin
                errors++;
                $display("Output appeared in %s before the commit", test_name);
            end
            if (expected_q.size() == 0) begin
                errors++;
                $display("Unexpected output in %s with id %h", test_name,
                         request_engine_out.payload.id);
            end else begin
                check_value(test_name, expected_q.pop_front(), request_engine_out.payload);
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        ap_clk                   = 1'b0;
        areset_csr_engine        = 1'b1;
        response_engine_in       = '0;
        response_memory_in       = '0;
        request_engine_out_rd_en = 1'b0;
        lfsr_state               = 32'hf8d4_6982;
        model_op                 = '0;
        model_operand            = '0;
        next_id                  = '0;
        hold_quiet               = 1'b0;
        errors                   = 0;
        errors_at_start          = 0;
        checks                   = 0;
        tests_run                = 0;
        repeat (3) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;

        test_name = "reset";
        repeat (2) @(posedge ap_clk);
        check_value("reset output valid", 0, request_engine_out.valid);
        check_value("reset engine status", 3'b010, response_engine_in_status);
        check_value("reset memory status", 3'b010, response_memory_in_status);
        check_value("reset output status", 3'b010, request_engine_out_status);
        finish_test();

        request_engine_out_rd_en <= 1'b1;
        for (int k = 0; k < 8; k++) begin
            test_name = $sformatf("op %0d", k);
            configure_alu(4'(k), random_bits(32));
            repeat (20) send_packet();
            idle_cycle();
            wait_drain();
            finish_test();
        end

        // Packets must wait in the engine FIFO until the commit
        test_name = "hold before commit";
        send_config(field_clear, '0);
        load_config(op_sub, random_bits(32));
        hold_quiet = 1'b1;
        repeat (8) send_packet();
        idle_cycle();
        repeat (50) @(posedge ap_clk);
        hold_quiet = 1'b0;
        send_config(field_commit, '0);
        idle_cycle();
        wait_drain();
        finish_test();

        test_name = "back-pressure";
        request_engine_out_rd_en <= 1'b0;
        configure_alu(op_add, random_bits(32));
        saw_full = 1'b0;
        for (int n = 0; n < 64 && !saw_full; n++) begin
            send_packet();
            idle_cycle();
            repeat (3) @(posedge ap_clk);
            saw_full = response_engine_in_status.full;
        end
        if (!saw_full) begin
            errors++;
            $display("Engine input FIFO never reported full under back-pressure");
        end
        check_value("output prog_full", 1, request_engine_out_status.prog_full);
        request_engine_out_rd_en <= 1'b1;
        wait_drain();
        finish_test();

        test_name = "pass-through";
        configure_alu(4'hc, random_bits(32));
        repeat (20) send_packet();
        idle_cycle();
        wait_drain();
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // About 40 cycles per packet plus a margin
    initial begin
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Run timed out in %s with %0d results outstanding", test_name,
                 expected_q.size());
        $display("TB FAILED");
        $finish;
    end

endmodule : engine_alu_ops_tb

/* engine_alu_ops.f */
rtl/alu_ops_pkg.sv
rtl/sync_fifo.sv
rtl/alu_ops_configure.sv
rtl/alu_ops_generator.sv
rtl/engine_alu_ops.sv
bench/engine_alu_ops_properties.sv
bench/engine_alu_ops_tb.sv

/* Bender.yml */
package:
  name: engine_alu_ops

sources:
  # RTL in compile order
  - rtl/alu_ops_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/alu_ops_configure.sv
  - rtl/alu_ops_generator.sv
  - rtl/engine_alu_ops.sv

  # Testbench and bound properties
  - target: test
    files:
      - bench/engine_alu_ops_properties.sv
      - bench/engine_alu_ops_tb.sv
